// File: hw/raster_config.svh
/*
 * build-time sizes for the rasterizer front end
 * command FIFO depth, command word width, coordinate width
 */

`ifndef RASTER_CONFIG_SVH
`define RASTER_CONFIG_SVH

// command FIFO entries, any value >= 2
`define RASTER_FIFO_DEPTH 16

// host command word
`define RASTER_WORD_W 32

// one vertex coordinate, two of them fill a word
`define RASTER_COORD_W 16

`endif

// File: hw/raster_cmd_pkg.sv
/*
 * command side types
 * header opcode enum and input decoder FSM states
 */

`default_nettype none

package raster_cmd_pkg;

	// opcode field, bits 31..28 of a header word
	typedef enum logic [3:0] {
		OP_TRIANGLE  = 4'd1,
		OP_FRAME_END = 4'd2
	} cmd_opcode_e;

	typedef enum logic [3:0] {
		IDLE,
		LATCH_HDR,
		WAIT_V1,
		LATCH_V1,
		WAIT_V2,
		LATCH_V2,
		WAIT_V3,
		LATCH_V3,
		FRAME_END
	} decoder_state_e;

endpackage

`default_nettype wire

// File: hw/raster_geom_pkg.sv
/*
 * geometry types
 * vertex, triangle and bounding box structs
 */

`default_nettype none

`include "raster_config.svh"

package raster_geom_pkg;

	// x in the upper half, matches the vertex word layout
	typedef struct packed {
		logic [`RASTER_COORD_W-1:0] x;
		logic [`RASTER_COORD_W-1:0] y;
	} vertex_t;

	typedef struct packed {
		vertex_t    v1;
		vertex_t    v2;
		vertex_t    v3;
		logic [7:0] tex_num;
	} triangle_t;

	typedef struct packed {
		logic [`RASTER_COORD_W-1:0] min_x;
		logic [`RASTER_COORD_W-1:0] min_y;
		logic [`RASTER_COORD_W-1:0] max_x;
		logic [`RASTER_COORD_W-1:0] max_y;
	} bbox_t;

endpackage

`default_nettype wire

// File: hw/cmd_fifo_if.sv
/*
 * command FIFO bus
 * host, reader and fifo modports
 */

`timescale 1ns/1ps
`default_nettype none

`include "raster_config.svh"

interface cmd_fifo_if ();

	logic                      write;
	logic [`RASTER_WORD_W-1:0] w_data;
	logic                      read;
	logic [`RASTER_WORD_W-1:0] r_data; // head word, valid while !empty
	logic                      empty;
	logic                      full;

	modport host (output write, w_data, input full);
	modport reader (output read, input r_data, empty);
	modport fifo (input write, w_data, read, output r_data, empty, full);

endinterface

`default_nettype wire

// File: hw/triangle_if.sv
/*
 * decoder to setup stage bus
 * triangle payload, ready pulses and the request level
 */

`timescale 1ns/1ps
`default_nettype none

interface triangle_if
	import raster_geom_pkg::*;
();

	logic      next_triangle; // level request from setup
	logic      data_ready;    // one cycle, tri_data valid
	logic      frame_ready;   // one cycle per frame word
	triangle_t tri_data;

	modport decoder (input next_triangle, output data_ready, frame_ready, tri_data);
	modport setup (output next_triangle, input data_ready, frame_ready, tri_data);

endinterface

`default_nettype wire

// File: hw/cmd_fifo.sv
/*
 * first-word-fall-through command FIFO
 * circular buffer with occupancy count, writes dropped while full
 */

`timescale 1ns/1ps
`default_nettype none

`include "raster_config.svh"

module cmd_fifo
(
	input logic clk,
	input logic reset,
	cmd_fifo_if.fifo bus
);

	localparam int DEPTH = `RASTER_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [`RASTER_WORD_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_write;
	logic do_read;

	// depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign bus.empty = (count == '0);
	assign bus.full = (count == CNT_W'(DEPTH));
	assign bus.r_data = mem[rd_ptr]; // fall through

	assign do_write = bus.write && !bus.full;
	assign do_read = bus.read && !bus.empty;

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_read)
				rd_ptr <= ptr_inc(rd_ptr);
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[wr_ptr] <= bus.w_data;
	end

endmodule

`default_nettype wire

// File: hw/input_decoder.sv
/*
 * command decoder FSM
 * pops header and three vertex words, builds the triangle,
 * pulses data_ready / frame_ready toward the setup stage
 */

`timescale 1ns/1ps
`default_nettype none

`include "raster_config.svh"

module input_decoder
	import raster_cmd_pkg::*;
	import raster_geom_pkg::*;
(
	input logic clk,
	input logic reset,
	cmd_fifo_if.reader fifo,
	triangle_if.decoder tri_bus
);

	decoder_state_e state;
	decoder_state_e next_state;

	cmd_opcode_e opcode;
	vertex_t     head_vtx;
	vertex_t     v1;
	vertex_t     v2;
	vertex_t     v3;
	logic [7:0]  tex_num;
	logic        latch_state;
	logic        pop;

	assign opcode = cmd_opcode_e'(fifo.r_data[`RASTER_WORD_W-1 -: 4]);
	assign head_vtx = fifo.r_data;

	assign latch_state = (state == LATCH_HDR) || (state == LATCH_V1) ||
		(state == LATCH_V2) || (state == LATCH_V3);

	// a latch state only pops a word that is there
	assign pop = latch_state && !fifo.empty;
	assign fifo.read = pop || (state == FRAME_END);

	assign tri_bus.data_ready = (state == LATCH_V3) && pop;
	assign tri_bus.frame_ready = (state == FRAME_END);

	// v3 forwarded from the head word during its own pop
	assign tri_bus.tri_data.v1 = v1;
	assign tri_bus.tri_data.v2 = v2;
	assign tri_bus.tri_data.v3 = tri_bus.data_ready ? head_vtx : v3;
	assign tri_bus.tri_data.tex_num = tex_num;

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
				if (tri_bus.next_triangle && !fifo.empty)
				begin
					case (opcode)
						OP_FRAME_END: next_state = FRAME_END;
						default:      next_state = LATCH_HDR; // unknown opcodes too
					endcase
				end
			LATCH_HDR: next_state = LATCH_V1; // header already seen at the head
			LATCH_V1:  next_state = pop ? LATCH_V2 : WAIT_V1;
			LATCH_V2:  next_state = pop ? LATCH_V3 : WAIT_V2;
			LATCH_V3:  next_state = pop ? IDLE : WAIT_V3;
			WAIT_V1:
				if (!fifo.empty)
					next_state = LATCH_V1;
			WAIT_V2:
				if (!fifo.empty)
					next_state = LATCH_V2;
			WAIT_V3:
				if (!fifo.empty)
					next_state = LATCH_V3;
			default:   next_state = IDLE; // FRAME_END
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk)
	begin
		if (pop)
		begin
			case (state)
				LATCH_HDR: tex_num <= fifo.r_data[7:0];
				LATCH_V1:  v1 <= head_vtx;
				LATCH_V2:  v2 <= head_vtx;
				default:   v3 <= head_vtx;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/triangle_setup.sv
/*
 * triangle setup stage
 * bounding box, twice the signed area, output register with
 * valid/ready, request back to the decoder, frame_done
 */

`timescale 1ns/1ps
`default_nettype none

`include "raster_config.svh"

module triangle_setup
	import raster_geom_pkg::*;
(
	input logic clk,
	input logic reset,
	triangle_if.setup tri_bus,
	output logic tri_valid,
	input logic tri_ready,
	output bbox_t bbox,
	output logic signed [2*`RASTER_COORD_W+1:0] area2,
	output logic [7:0] tex_num,
	output logic frame_done
);

	localparam int CW = `RASTER_COORD_W;

	triangle_t t;
	bbox_t bbox_next;
	logic signed [CW:0] dx21, dy31, dx31, dy21; // one extra bit for the sign
	logic signed [2*CW+1:0] prod_a, prod_b;
	logic req_en;

	function automatic logic [CW-1:0] min3(input logic [CW-1:0] a, b, c);
		logic [CW-1:0] m;
		m = (a < b) ? a : b;
		return (m < c) ? m : c;
	endfunction

	function automatic logic [CW-1:0] max3(input logic [CW-1:0] a, b, c);
		logic [CW-1:0] m;
		m = (a > b) ? a : b;
		return (m > c) ? m : c;
	endfunction

	assign t = tri_bus.tri_data;

	assign bbox_next.min_x = min3(t.v1.x, t.v2.x, t.v3.x);
	assign bbox_next.min_y = min3(t.v1.y, t.v2.y, t.v3.y);
	assign bbox_next.max_x = max3(t.v1.x, t.v2.x, t.v3.x);
	assign bbox_next.max_y = max3(t.v1.y, t.v2.y, t.v3.y);

	// coordinates are unsigned, differences are not
	assign dx21 = $signed({1'b0, t.v2.x}) - $signed({1'b0, t.v1.x});
	assign dy31 = $signed({1'b0, t.v3.y}) - $signed({1'b0, t.v1.y});
	assign dx31 = $signed({1'b0, t.v3.x}) - $signed({1'b0, t.v1.x});
	assign dy21 = $signed({1'b0, t.v2.y}) - $signed({1'b0, t.v1.y});
	assign prod_a = dx21 * dy31;
	assign prod_b = dx31 * dy21;

	// ask for more while the output slot is free or emptying
	assign tri_bus.next_triangle = req_en && (!tri_valid || tri_ready);

	always_ff @(posedge clk)
	begin
		if (!reset)
		begin
			tri_valid <= 1'b0;
			frame_done <= 1'b0;
			req_en <= 1'b0;
		end
		else
		begin
			req_en <= 1'b1; // no request in the first cycle out of reset
			frame_done <= tri_bus.frame_ready;
			if (tri_bus.data_ready)
				tri_valid <= 1'b1;
			else if (tri_ready)
				tri_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (tri_bus.data_ready)
		begin
			bbox <= bbox_next;
			area2 <= prod_a - prod_b;
			tex_num <= t.tex_num;
		end
	end

endmodule

`default_nettype wire

// File: hw/raster_front_end.sv
/*
 * rasterizer front end top
 * command FIFO, input decoder and triangle setup on plain ports
 */

`timescale 1ns/1ps
`default_nettype none

`include "raster_config.svh"

module raster_front_end
	import raster_geom_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic fifo_write,
	input logic [`RASTER_WORD_W-1:0] fifo_w_data,
	output logic fifo_full,
	output logic tri_valid,
	input logic tri_ready,
	output logic [`RASTER_COORD_W-1:0] min_x,
	output logic [`RASTER_COORD_W-1:0] min_y,
	output logic [`RASTER_COORD_W-1:0] max_x,
	output logic [`RASTER_COORD_W-1:0] max_y,
	output logic signed [2*`RASTER_COORD_W+1:0] area2,
	output logic [7:0] tex_num,
	output logic frame_done
);

	cmd_fifo_if cmd_bus ();
	triangle_if tri_if ();

	bbox_t bbox;

	// host side of the FIFO
	assign cmd_bus.write = fifo_write;
	assign cmd_bus.w_data = fifo_w_data;
	assign fifo_full = cmd_bus.full;

	cmd_fifo cmd_fifo_i (
		.clk(clk),
		.reset(reset),
		.bus(cmd_bus.fifo)
	);

	input_decoder input_decoder_i (
		.clk(clk),
		.reset(reset),
		.fifo(cmd_bus.reader),
		.tri_bus(tri_if.decoder)
	);

	triangle_setup triangle_setup_i (
		.clk(clk),
		.reset(reset),
		.tri_bus(tri_if.setup),
		.tri_valid(tri_valid),
		.tri_ready(tri_ready),
		.bbox(bbox),
		.area2(area2),
		.tex_num(tex_num),
		.frame_done(frame_done)
	);

	assign min_x = bbox.min_x;
	assign min_y = bbox.min_y;
	assign max_x = bbox.max_x;
	assign max_y = bbox.max_y;

endmodule

`default_nettype wire

// File: tests/raster_front_end_assertions.sv
/*
 * concurrent checks on the front end outputs
 * hold under back-pressure, single-cycle frame_done, reset state
 * and a count of failed assertions
 */

`timescale 1ns/1ps
`default_nettype none

`include "raster_config.svh"

module raster_front_end_assertions
(
	input logic clk,
	input logic reset,
	input logic tri_valid,
	input logic tri_ready,
	input logic [`RASTER_COORD_W-1:0] min_x,
	input logic [`RASTER_COORD_W-1:0] min_y,
	input logic [`RASTER_COORD_W-1:0] max_x,
	input logic [`RASTER_COORD_W-1:0] max_y,
	input logic signed [2*`RASTER_COORD_W+1:0] area2,
	input logic [7:0] tex_num,
	input logic frame_done
);

	int failures = 0; // read by the testbench at the end

	// stalled output holds everything
	output_hold: assert property (@(posedge clk) disable iff (!reset)
		(tri_valid && !tri_ready) |=> (tri_valid && $stable(min_x) && $stable(min_y) &&
		$stable(max_x) && $stable(max_y) && $stable(area2) && $stable(tex_num)))
		else
		begin
			failures++;
			$error("output changed while stalled");
		end

	frame_pulse: assert property (@(posedge clk) disable iff (!reset)
		frame_done |=> !frame_done)
		else
		begin
			failures++;
			$error("frame_done high for two cycles");
		end

	reset_clears: assert property (@(posedge clk) !reset |=> !tri_valid)
		else
		begin
			failures++;
			$error("tri_valid high after reset");
		end

endmodule

bind raster_front_end raster_front_end_assertions raster_front_end_assertions_i (.*);

`default_nettype wire

// File: tests/raster_front_end_tb.sv
/*
 * testbench for the rasterizer front end
 * random command stream against a triangle model, FIFO fill test,
 * timeout and final report
 */

`timescale 1ns/1ps
`default_nettype none

`include "raster_config.svh"

module raster_front_end_tb;

	localparam int CW = `RASTER_COORD_W;
	localparam int NUM_CMDS = 60;
	localparam int FILL_MAX = 8;
	localparam int CYCLE_LIMIT = 40 * (NUM_CMDS * 4 + FILL_MAX * 4 + 1) + 200;

	typedef struct packed {
		logic [CW-1:0]          min_x;
		logic [CW-1:0]          min_y;
		logic [CW-1:0]          max_x;
		logic [CW-1:0]          max_y;
		logic signed [2*CW+1:0] area2;
		logic [7:0]             tex_num;
	} expect_t;

	logic clk = 1'b0;
	logic reset;
	logic fifo_write;
	logic [`RASTER_WORD_W-1:0] fifo_w_data;
	logic fifo_full;
	logic tri_valid;
	logic tri_ready;
	logic [CW-1:0] min_x;
	logic [CW-1:0] min_y;
	logic [CW-1:0] max_x;
	logic [CW-1:0] max_y;
	logic signed [2*CW+1:0] area2;
	logic [7:0] tex_num;
	logic frame_done;

	expect_t expected [$];   // triangles not yet accepted
	int frame_marks [$];     // triangles written before each frame word
	int tri_written = 0;
	int accepted = 0;
	int frames_written = 0;
	int frames_seen = 0;
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	bit hold_ready = 1'b0;

	raster_front_end raster_front_end_i (.*);

	initial
	begin
		forever #2 clk = ~clk;
	end

	// run limit, counted in clock cycles
	initial
	begin
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("SOME TESTS FAILED");
		$finish;
	end

	task automatic check(input string what, input logic signed [63:0] got,
		input logic signed [63:0] want);
		checks++;
		if (got !== want)
		begin
			$display("Mismatch at %0t ns: %s, got %0d expected %0d", $time, what, got, want);
			errors++;
		end
	endtask

	// bounding box by scanning the three vertices, area by the cross product
	function automatic expect_t model_triangle(input logic [31:0] hdr, w1, w2, w3);
		expect_t e;
		longint x [3];
		longint y [3];
		int i;
		x[0] = w1[31:16];
		y[0] = w1[15:0];
		x[1] = w2[31:16];
		y[1] = w2[15:0];
		x[2] = w3[31:16];
		y[2] = w3[15:0];
		e.min_x = '1;
		e.min_y = '1;
		e.max_x = '0;
		e.max_y = '0;
		for (i = 0; i < 3; i++)
		begin
			if (x[i] < e.min_x)
				e.min_x = x[i];
			if (x[i] > e.max_x)
				e.max_x = x[i];
			if (y[i] < e.min_y)
				e.min_y = y[i];
			if (y[i] > e.max_y)
				e.max_y = y[i];
		end
		e.area2 = (x[1] - x[0]) * (y[2] - y[0]) - (x[2] - x[0]) * (y[1] - y[0]);
		e.tex_num = hdr[7:0];
		return e;
	endfunction

	// tri_ready is picked here, so an acceptance is known one half cycle ahead
	task automatic check_outputs();
		tri_ready = hold_ready ? 1'b0 : ($urandom % 4 != 0);
		if (frame_done)
		begin
			frames_seen++;
			if (frame_marks.size() == 0)
			begin
				$display("frame_done pulsed at %0t ns with no frame word written", $time);
				errors++;
			end
			else
			begin
				if (accepted + int'(tri_valid) < frame_marks[0])
				begin
					$display("frame_done at %0t ns came before earlier triangles left", $time);
					errors++;
				end
				void'(frame_marks.pop_front());
			end
		end
		if (tri_valid && expected.size() == 0)
		begin
			$display("tri_valid high at %0t ns with no triangle outstanding", $time);
			errors++;
		end
		else if (tri_valid)
		begin
			check("min_x", min_x, expected[0].min_x);
			check("min_y", min_y, expected[0].min_y);
			check("max_x", max_x, expected[0].max_x);
			check("max_y", max_y, expected[0].max_y);
			check("area2", area2, expected[0].area2);
			check("tex_num", tex_num, expected[0].tex_num);
			if (tri_ready)
				void'(expected.pop_front());
		end
		if (tri_valid && tri_ready)
			accepted++;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		check_outputs();
		fifo_write = 1'b0;
	endtask

	task automatic write_word(input logic [31:0] word);
		@(negedge clk);
		check_outputs();
		while (fifo_full)
		begin
			fifo_write = 1'b0;
			@(negedge clk);
			check_outputs();
		end
		fifo_write = 1'b1;
		fifo_w_data = word;
	endtask

	// written while full, the FIFO must drop it
	task automatic drop_word();
		@(negedge clk);
		check_outputs();
		fifo_write = 1'b1;
		fifo_w_data = {4'd2, 28'($urandom)};
	endtask

	task automatic write_triangle();
		logic [31:0] hdr;
		logic [31:0] w1;
		logic [31:0] w2;
		logic [31:0] w3;
		logic [3:0] op;
		op = 4'($urandom % 16);
		if (op == 4'd2)
			op = 4'd1; // unknown opcodes still build triangles
		hdr = {op, 20'($urandom), 8'($urandom)};
		w1 = $urandom;
		w2 = $urandom;
		w3 = $urandom;
		write_word(hdr);
		write_word(w1);
		write_word(w2);
		write_word(w3);
		expected.push_back(model_triangle(hdr, w1, w2, w3));
		tri_written++;
	endtask

	task automatic write_frame();
		write_word({4'd2, 28'($urandom)});
		frame_marks.push_back(tri_written);
		frames_written++;
	endtask

	task automatic drain();
		idle_cycle();
		while (expected.size() != 0 || frame_marks.size() != 0)
			idle_cycle();
	endtask

	task automatic end_test(input string name, input int errors_before);
		$display("test %s: %s", name, (errors == errors_before) ? "pass" : "fail");
	endtask

	initial
	begin
		int start_errors;
		int n;
		void'($urandom(32'ha4a6_fdf7));
		reset = 1'b0;
		fifo_write = 1'b0;
		fifo_w_data = '0;
		tri_ready = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b1;

		start_errors = errors;
		check("tri_valid after reset", tri_valid, 0);
		check("frame_done after reset", frame_done, 0);
		check("fifo_full after reset", fifo_full, 0);
		end_test("reset", start_errors);

		start_errors = errors;
		for (n = 0; n < NUM_CMDS; n++)
		begin
			if ($urandom % 8 == 0)
				write_frame();
			else
				write_triangle();
		end
		drain();
		end_test("random", start_errors);

		start_errors = errors;
		hold_ready = 1'b1; // consumer stalled, FIFO backs up
		n = 0;
		do
		begin
			write_triangle();
			idle_cycle();
			n++;
		end
		while (!fifo_full && n < FILL_MAX);
		check("fifo_full after fill", fifo_full, 1);
		drop_word();
		idle_cycle();
		check("fifo_full after dropped write", fifo_full, 1);
		hold_ready = 1'b0;
		drain();
		end_test("fill", start_errors);

		start_errors = errors;
		check("frame_done count", frames_seen, frames_written);
		check("accepted triangles", accepted, tri_written);
		check("assertion failures", raster_front_end_i.raster_front_end_assertions_i.failures, 0);
		end_test("totals", start_errors);

		$display("checks %0d, errors %0d, triangles %0d, frames %0d",
			checks, errors, accepted, frames_seen);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/raster_cmd_pkg.sv
hw/raster_geom_pkg.sv
hw/cmd_fifo_if.sv
hw/triangle_if.sv
hw/cmd_fifo.sv
hw/input_decoder.sv
hw/triangle_setup.sv
hw/raster_front_end.sv
tests/raster_front_end_assertions.sv
tests/raster_front_end_tb.sv
